// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_pov
RTL_TOP    ?= pov_top
FLIST      ?= list.f
OBJ_DIR    ?= obj_dir
PASS_MSG   ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== frame_manager.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_manager import pov_pkg::*; #(
    parameter int NUM_ROWS  = 64,
    parameter int SCAN_RATE = 32,   // power of two
    parameter int THETA_RES = 10
) (
    input  wire                          sysclk,
    input  wire                          arst_n,
    input  wire                          mode,          // MODE_BARS / MODE_SPHERE
    input  wire  [THETA_RES-1:0]         theta,
    input  wire                          hub75_ready,
    output pixel_t [1:0][NUM_ROWS-1:0]   columns,       // [0] upper half, [1] lower
    output logic [$clog2(SCAN_RATE)-1:0] col_num,
    output logic                         data_valid
);

    localparam int ADDR_W = $clog2(SCAN_RATE);
    localparam int ROW_W  = $clog2(NUM_ROWS);
    localparam int GRID_ROW_BITS   = 3;   // grid line every 8 rows
    localparam int GRID_THETA_BITS = 5;   // and every 32 slices

    logic                 load_req;    // build columns this cycle
    logic                 xfer;
    logic [THETA_RES-1:0] theta_scan;  // theta frozen for one scan
    logic [THETA_RES-1:0] theta_use;
    pixel_t [1:0][NUM_ROWS-1:0] next_cols;

    assign xfer = data_valid & hub75_ready;

    // address 0 opens a new scan and takes a fresh theta
    assign theta_use = (col_num == '0) ? theta : theta_scan;

    // pixel generation for both columns
    always_comb begin : build_cols
        logic [ADDR_W:0]   line_idx;
        logic [ROW_W-1:0]  row_idx;
        logic [CH_W-1:0]   red;
        logic [CH_W-1:0]   grn;
        logic [CH_W-1:0]   blu;
        logic              grid;
        for (int c = 0; c < 2; c++) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                line_idx = {1'(c), col_num};   // a, or a + SCAN_RATE
                row_idx  = ROW_W'(r);
                grid     = (row_idx[GRID_ROW_BITS-1:0] == '0) ||
                           (theta_use[GRID_THETA_BITS-1:0] == '0);
                if (mode == MODE_SPHERE) begin
                    red = grid ? '1 : '0;
                    grn = grid ? '1 : '0;
                    blu = grid ? '1 : CH_W'(1);   // white lines on dim blue
                end else begin
                    red = theta_use[CH_W-1:0];
                    grn = line_idx[CH_W-1:0];
                    blu = row_idx[CH_W-1:0];
                end
                next_cols[c][r].raw = {red, grn, blu};
            end
        end
    end

    // handshake and scan stepping
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            load_req   <= 1'b1;   // first build right after reset
            data_valid <= 1'b0;
            col_num    <= '0;
            theta_scan <= '0;
        end else if (load_req) begin
            load_req   <= 1'b0;
            data_valid <= 1'b1;
            if (col_num == '0)
                theta_scan <= theta;   // hold for the rest of the scan
        end else if (xfer) begin
            data_valid <= 1'b0;        // one dead cycle while rebuilding
            load_req   <= 1'b1;
            col_num    <= col_num + 1'b1;   // wraps at SCAN_RATE
        end
    end

    // column registers, payload only
    always_ff @(posedge sysclk) begin
        if (load_req)
            columns <= next_cols;
    end

endmodule

`default_nettype wire

// ==== hub75_output.sv ====
`timescale 1ns/1ps
`default_nettype none

module hub75_output import pov_pkg::*; #(
    parameter int NUM_ROWS  = 64,
    parameter int SCAN_RATE = 32,
    parameter int OE_UNIT   = 4     // plane 0 on time, cycles
) (
    input  wire                          sysclk,
    input  wire                          arst_n,
    input  wire pixel_t [1:0][NUM_ROWS-1:0] column_data,
    input  wire  [$clog2(SCAN_RATE)-1:0] col_index,
    input  wire                          tvalid,
    output logic                         tready,
    output logic [$clog2(SCAN_RATE)-1:0] addr,
    output logic [2:0]                   rgb0,        // {b, g, r}, upper half
    output logic [2:0]                   rgb1,        // {b, g, r}, lower half
    output logic                         led_latch,
    output logic                         led_output_enable_n,
    output logic                         led_clk
);

    localparam int ROW_W   = $clog2(NUM_ROWS);
    localparam int PLANE_W = $clog2(CH_W);
    localparam int DISP_W  = $clog2((OE_UNIT << (CH_W - 1)) + 1);
    localparam logic [PLANE_W-1:0] LAST_PLANE = PLANE_W'(CH_W - 1);

    // FSM states
    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_SHIFT = 2'd1;
    localparam logic [1:0] S_LATCH = 2'd2;
    localparam logic [1:0] S_DISP  = 2'd3;

    logic [1:0]         state;
    logic [ROW_W-1:0]   row_cnt;    // counts down to row 0
    logic [PLANE_W-1:0] plane;      // current bit plane
    logic [DISP_W-1:0]  disp_cnt;   // remaining on time
    pixel_t [1:0][NUM_ROWS-1:0] col_buf;
    pixel_t             pix0;
    pixel_t             pix1;

    // current pixel pair, field view picks the plane
    assign pix0 = col_buf[0][row_cnt];
    assign pix1 = col_buf[1][row_cnt];

    always_comb begin
        if (state == S_SHIFT) begin
            rgb0 = {pix0.f.b[plane], pix0.f.g[plane], pix0.f.r[plane]};
            rgb1 = {pix1.f.b[plane], pix1.f.g[plane], pix1.f.r[plane]};
        end else begin
            rgb0 = '0;   // quiet bus between shifts
            rgb1 = '0;
        end
    end

    // FSM
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state               <= S_IDLE;
            tready              <= 1'b1;
            addr                <= '0;
            row_cnt             <= '0;
            plane               <= '0;
            disp_cnt            <= '0;
            led_latch           <= 1'b0;
            led_output_enable_n <= 1'b1;   // dark
            led_clk             <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (tvalid) begin
                        tready  <= 1'b0;       // busy for the whole pair
                        addr    <= col_index;
                        row_cnt <= ROW_W'(NUM_ROWS - 1);
                        plane   <= '0;
                        led_clk <= 1'b0;
                        state   <= S_SHIFT;
                    end
                end
                S_SHIFT: begin
                    if (!led_clk) begin
                        led_clk <= 1'b1;       // data settled last cycle
                    end else begin
                        led_clk <= 1'b0;
                        if (row_cnt == '0) begin
                            led_latch <= 1'b1; // whole plane shifted
                            state     <= S_LATCH;
                        end else begin
                            row_cnt <= row_cnt - 1'b1;
                        end
                    end
                end
                S_LATCH: begin
                    led_latch           <= 1'b0;
                    led_output_enable_n <= 1'b0;
                    disp_cnt            <= DISP_W'((OE_UNIT << plane) - 1);  // binary weight
                    state               <= S_DISP;
                end
                default: begin   // S_DISP
                    if (disp_cnt == '0) begin
                        led_output_enable_n <= 1'b1;
                        if (plane == LAST_PLANE) begin
                            tready <= 1'b1;
                            state  <= S_IDLE;
                        end else begin
                            plane   <= plane + 1'b1;
                            row_cnt <= ROW_W'(NUM_ROWS - 1);
                            state   <= S_SHIFT;
                        end
                    end else begin
                        disp_cnt <= disp_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    // column buffer, taken on acceptance
    always_ff @(posedge sysclk) begin
        if (state == S_IDLE && tvalid)
            col_buf <= column_data;
    end

endmodule

`default_nettype wire

// ==== list.f ====
pov_pkg.sv
rotation_tracker.sv
frame_manager.sv
hub75_output.sv
pov_top.sv
tb_clock_gen.sv
tb_pov.sv

// ==== pov_pkg.sv ====
`default_nettype none

package pov_pkg;

    // colour depth, one bit plane per channel bit
    localparam int CH_W    = 3;
    localparam int RGB_RES = 3 * CH_W;   // r, g, b packed in one word

    // revolution period counter, saturates at all ones
    localparam int PERIOD_W = 24;

    // image select, straight from the mode pin
    localparam logic MODE_BARS   = 1'b0;
    localparam logic MODE_SPHERE = 1'b1;

    // channel view of a pixel word
    typedef struct packed {
        logic [CH_W-1:0] r;   // upper bits
        logic [CH_W-1:0] g;
        logic [CH_W-1:0] b;   // lower bits
    } rgb_fields_t;

    // one pixel word
    // frame side writes raw, panel side picks planes out of f
    typedef union packed {
        logic [RGB_RES-1:0] raw;
        rgb_fields_t        f;
    } pixel_t;

endpackage

`default_nettype wire

// ==== pov_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pov_top import pov_pkg::*; #(
    parameter int NUM_ROWS       = 64,
    parameter int SCAN_RATE      = 32,   // power of two
    parameter int THETA_RES      = 10,
    parameter int ROTATIONAL_RES = 256,  // power of two
    parameter int OE_UNIT        = 4
) (
    input  wire                          sysclk,
    input  wire                          arst_n,
    input  wire                          ir_tripped,   // rotor index sensor
    input  wire                          mode,         // image select
    output logic [1:0]                   led,
    output logic [$clog2(SCAN_RATE)-1:0] hub75_addr,
    output logic [2:0]                   hub75_rgb0,
    output logic [2:0]                   hub75_rgb1,
    output logic                         hub75_latch,
    output logic                         hub75_oe_n,
    output logic                         hub75_clk
);

    logic [THETA_RES-1:0]         theta;
    pixel_t [1:0][NUM_ROWS-1:0]   columns;
    logic [$clog2(SCAN_RATE)-1:0] col_num;
    logic                         data_valid;
    logic                         hub75_ready;

    assign led[1] = 1'b0;   // spare led off

    rotation_tracker #(
        .THETA_RES      (THETA_RES),
        .ROTATIONAL_RES (ROTATIONAL_RES)
    ) u_tracker (
        .sysclk     (sysclk),
        .arst_n     (arst_n),
        .ir_tripped (ir_tripped),
        .theta      (theta),
        .ir_led     (led[0])
    );

    frame_manager #(
        .NUM_ROWS  (NUM_ROWS),
        .SCAN_RATE (SCAN_RATE),
        .THETA_RES (THETA_RES)
    ) u_frame (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .mode        (mode),
        .theta       (theta),
        .hub75_ready (hub75_ready),
        .columns     (columns),
        .col_num     (col_num),
        .data_valid  (data_valid)
    );

    hub75_output #(
        .NUM_ROWS  (NUM_ROWS),
        .SCAN_RATE (SCAN_RATE),
        .OE_UNIT   (OE_UNIT)
    ) u_hub75 (
        .sysclk              (sysclk),
        .arst_n              (arst_n),
        .column_data         (columns),
        .col_index           (col_num),
        .tvalid              (data_valid),
        .tready              (hub75_ready),
        .addr                (hub75_addr),
        .rgb0                (hub75_rgb0),
        .rgb1                (hub75_rgb1),
        .led_latch           (hub75_latch),
        .led_output_enable_n (hub75_oe_n),
        .led_clk             (hub75_clk)
    );

endmodule

`default_nettype wire

// ==== rotation_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rotation_tracker import pov_pkg::*; #(
    parameter int THETA_RES      = 10,
    parameter int ROTATIONAL_RES = 256   // power of two
) (
    input  wire                  sysclk,
    input  wire                  arst_n,
    input  wire                  ir_tripped,   // async, from the rotor sensor
    output logic [THETA_RES-1:0] theta,
    output logic                 ir_led
);

    localparam int SLICE_SHIFT = $clog2(ROTATIONAL_RES);
    localparam logic [THETA_RES-1:0] THETA_MAX = THETA_RES'(ROTATIONAL_RES - 1);

    logic                ir_meta;         // first sync stage
    logic                ir_sync;         // second sync stage
    logic                ir_prev;         // for edge detect
    logic                index_pulse;     // one cycle per revolution
    logic                armed;           // first index seen
    logic [PERIOD_W-1:0] period_cnt;      // cycles since last index
    logic [PERIOD_W-1:0] period_latched;  // last full revolution
    logic [PERIOD_W-1:0] slice_len;
    logic [PERIOD_W-1:0] slice_cnt;

    // two flop synchroniser
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            ir_meta <= 1'b0;
            ir_sync <= 1'b0;
            ir_prev <= 1'b0;
        end else begin
            ir_meta <= ir_tripped;
            ir_sync <= ir_meta;
            ir_prev <= ir_sync;
        end
    end

    assign index_pulse = ir_sync & ~ir_prev;   // rising edge only
    assign ir_led      = ir_sync;              // status mirror

    // period measurement
    // count from reset to the first pulse is only a partial turn, so skip it
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            period_cnt     <= '0;
            period_latched <= '0;
            armed          <= 1'b0;
        end else if (index_pulse) begin
            period_cnt <= '0;
            armed      <= 1'b1;
            if (armed)
                period_latched <= period_cnt;
        end else if (period_cnt != '1) begin
            period_cnt <= period_cnt + 1'b1;   // saturate on a stalled rotor
        end
    end

    // equal slices by shift
    assign slice_len = period_latched >> SLICE_SHIFT;

    // slice counter and angle index
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            slice_cnt <= '0;
            theta     <= '0;
        end else if (index_pulse) begin
            slice_cnt <= '0;
            theta     <= '0;                   // back to the index angle
        end else if (slice_len == '0) begin
            slice_cnt <= '0;                   // no period yet, hold at 0
            theta     <= '0;
        end else if (slice_cnt == slice_len - 1'b1) begin
            slice_cnt <= '0;
            if (theta != THETA_MAX)
                theta <= theta + 1'b1;         // stop at last slice
        end else begin
            slice_cnt <= slice_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 10,   // 20 ns clock
    parameter int RESET_CYCLES = 10
) (
    output logic sysclk,
    output logic arst_n,
    input  wire  reset_req             // ask for another reset pulse
);

    initial begin
        sysclk = 1'b0;
        forever #HALF_PERIOD sysclk = ~sysclk;
    end

    // power-on reset, then one more on each request
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge sysclk);
        #2 arst_n = 1'b1;
        forever begin
            @(posedge sysclk);
            if (reset_req) begin
                #2 arst_n = 1'b0;
                repeat (RESET_CYCLES) @(posedge sysclk);
                #2 arst_n = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_pov.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pov import pov_pkg::*;;

    localparam int NUM_ROWS       = 64;
    localparam int SCAN_RATE      = 32;
    localparam int THETA_RES      = 10;
    localparam int ROTATIONAL_RES = 256;
    localparam int OE_UNIT        = 4;
    localparam int PIX_W          = 9;                     // r, g, b of 3 bits
    localparam int PAIR_W         = 2 * NUM_ROWS * PIX_W;
    localparam int PAIR_TIMEOUT   = 2000;                  // cycles per column pair, generous

    logic       sysclk;
    logic       arst_n;
    logic       reset_req;
    logic       ir_tripped;
    logic       mode;
    logic [1:0] led;
    logic [4:0] hub75_addr;
    logic [2:0] hub75_rgb0;
    logic [2:0] hub75_rgb1;
    logic       hub75_latch;
    logic       hub75_oe_n;
    logic       hub75_clk;

    int unsigned cycle_cnt = 0;
    int          err_cnt   = 0;
    int          chk_cnt   = 0;
    logic [15:0] lfsr_state;

    // panel monitor state
    logic [PIX_W-1:0] acc0 [NUM_ROWS];   // upper half pixels
    logic [PIX_W-1:0] acc1 [NUM_ROWS];   // lower half pixels
    int mon_plane;
    int mon_clks;
    int mon_oe;
    int mon_t0;
    int mon_row;
    int plane_clks [3];
    int plane_oe   [3];
    int plane_addr [3];

    // one entry per finished column pair (three per pair for the plane queues)
    int               pair_addr  [$];
    int               pair_time  [$];   // cycle of plane 0 latch
    int               pair_clks  [$];
    int               pair_oe    [$];
    int               pair_laddr [$];
    logic [PAIR_W-1:0] pair_pix  [$];

    tb_clock_gen u_clk (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .reset_req (reset_req)
    );

    pov_top #(
        .NUM_ROWS       (NUM_ROWS),
        .SCAN_RATE      (SCAN_RATE),
        .THETA_RES      (THETA_RES),
        .ROTATIONAL_RES (ROTATIONAL_RES),
        .OE_UNIT        (OE_UNIT)
    ) UUT (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .ir_tripped  (ir_tripped),
        .mode        (mode),
        .led         (led),
        .hub75_addr  (hub75_addr),
        .hub75_rgb0  (hub75_rgb0),
        .hub75_rgb1  (hub75_rgb1),
        .hub75_latch (hub75_latch),
        .hub75_oe_n  (hub75_oe_n),
        .hub75_clk   (hub75_clk)
    );

    always @(posedge sysclk) cycle_cnt++;

    // passive panel model, samples mid cycle
    always @(negedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            mon_plane = 0;
            mon_clks  = 0;
            mon_oe    = 0;
            for (int r = 0; r < NUM_ROWS; r++) begin
                acc0[r] = '0;
                acc1[r] = '0;
            end
        end else begin
            if (hub75_clk && mon_clks < NUM_ROWS) begin
                mon_row = NUM_ROWS - 1 - mon_clks;   // top row goes out first
                acc0[mon_row][6 + mon_plane] = hub75_rgb0[0];
                acc0[mon_row][3 + mon_plane] = hub75_rgb0[1];
                acc0[mon_row][mon_plane]     = hub75_rgb0[2];
                acc1[mon_row][6 + mon_plane] = hub75_rgb1[0];
                acc1[mon_row][3 + mon_plane] = hub75_rgb1[1];
                acc1[mon_row][mon_plane]     = hub75_rgb1[2];
            end
            if (hub75_clk)
                mon_clks++;
            if (hub75_latch) begin
                plane_addr[mon_plane] = hub75_addr;
                plane_clks[mon_plane] = mon_clks;
                mon_clks = 0;
                if (mon_plane == 0)
                    mon_t0 = cycle_cnt;
            end
            if (!hub75_oe_n) begin
                mon_oe++;
            end else if (mon_oe > 0) begin
                // end of a display window
                plane_oe[mon_plane] = mon_oe;
                mon_oe = 0;
                if (mon_plane == CH_W - 1) begin
                    store_pair();
                    mon_plane = 0;
                end else begin
                    mon_plane++;
                end
            end
        end
    end

    task automatic store_pair();
        logic [PAIR_W-1:0] pix;
        for (int r = 0; r < NUM_ROWS; r++) begin
            pix[r * PIX_W +: PIX_W]              = acc0[r];
            pix[(NUM_ROWS + r) * PIX_W +: PIX_W] = acc1[r];
            acc0[r] = '0;
            acc1[r] = '0;
        end
        pair_pix.push_back(pix);
        pair_addr.push_back(plane_addr[0]);
        pair_time.push_back(mon_t0);
        for (int p = 0; p < 3; p++) begin
            pair_clks.push_back(plane_clks[p]);
            pair_oe.push_back(plane_oe[p]);
            pair_laddr.push_back(plane_addr[p]);
        end
    endtask

    // 16 bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int rand_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);   // one step per bit
            v = (v << 1) | lfsr_state[0];
        end
        return v;
    endfunction

    task automatic check_value(string name, int expected, int actual);
        chk_cnt++;
        if (expected != actual) begin
            err_cnt++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic report_test(string name, int errs_before);
        if (err_cnt == errs_before)
            $display("test %s finished, no errors", name);
        else
            $display("test %s finished, %0d errors", name, err_cnt - errs_before);
    endtask

    task automatic abort_run(string what);
        $display("timeout: %s", what);
        $display("Verification failed");
        $finish;
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (!arst_n && n < 100) begin
            @(posedge sysclk);
            n++;
        end
        if (!arst_n)
            abort_run("reset never released");
        else
            #2;
    endtask

    task automatic wait_pairs(int count);
        int target;
        int n;
        target = pair_addr.size() + count;
        n      = 0;
        while (pair_addr.size() < target && n < count * PAIR_TIMEOUT) begin
            @(posedge sysclk);
            n++;
        end
        if (pair_addr.size() < target)
            abort_run("panel stopped sending column pairs");
        else
            #2;
    endtask

    task automatic clear_capture();
        pair_addr.delete();
        pair_time.delete();
        pair_clks.delete();
        pair_oe.delete();
        pair_laddr.delete();
        pair_pix.delete();
    endtask

    task automatic apply_reset();
        @(posedge sysclk);
        #2 reset_req = 1'b1;
        @(posedge sysclk);
        #2 reset_req = 1'b0;
        @(posedge sysclk);
        wait_reset_release();
        clear_capture();
    endtask

    function automatic logic [PIX_W-1:0] pair_pixel(int idx, int c, int r);
        return pair_pix[idx][(c * NUM_ROWS + r) * PIX_W +: PIX_W];
    endfunction

    // bars image: red theta, green line index, blue row
    function automatic logic [PIX_W-1:0] bars_pixel(int c, int a, int r, int th);
        int line;
        line = a + c * SCAN_RATE;
        return {3'(th), 3'(line), 3'(r)};
    endfunction

    task automatic test_reset();
        int e0;
        e0 = err_cnt;
        check_value("reset latch", 0, hub75_latch);
        check_value("reset oe_n", 1, hub75_oe_n);
        check_value("reset clk", 0, hub75_clk);
        check_value("reset led1", 0, led[1]);
        wait_pairs(1);
        check_value("reset first address", 0, pair_laddr[0]);
        report_test("reset", e0);
    endtask

    task automatic test_bars();
        int e0;
        e0 = err_cnt;
        wait_pairs(2);   // flush pairs built earlier
        clear_capture();
        wait_pairs(SCAN_RATE + 2);   // long enough to wrap the address
        for (int i = 0; i < SCAN_RATE + 2; i++) begin
            if (i > 0)
                check_value("bars address order", (pair_addr[i-1] + 1) % SCAN_RATE,
                            pair_addr[i]);
            for (int p = 1; p < 3; p++)   // later planes keep the address
                check_value("bars latch address", pair_addr[i], pair_laddr[i*3 + p]);
            for (int c = 0; c < 2; c++)
                for (int r = 0; r < NUM_ROWS; r++)
                    check_value("bars pixel", bars_pixel(c, pair_addr[i], r, 0),
                                pair_pixel(i, c, r));
        end
        report_test("bars", e0);
    endtask

    task automatic test_planes();
        int e0;
        e0 = err_cnt;
        clear_capture();
        wait_pairs(3);
        for (int i = 0; i < 3; i++)
            for (int p = 0; p < 3; p++) begin
                check_value("plane clock edges", NUM_ROWS, pair_clks[i*3 + p]);
                check_value("plane on time", OE_UNIT << p, pair_oe[i*3 + p]);
            end
        report_test("planes", e0);
    endtask

    task automatic test_sphere();
        int e0;
        e0 = err_cnt;
        @(posedge sysclk);
        #2 mode = MODE_SPHERE;
        wait_pairs(2);
        clear_capture();
        wait_pairs(3);
        // theta 0 is a grid line, so all white
        for (int i = 0; i < 3; i++)
            for (int c = 0; c < 2; c++)
                for (int r = 0; r < NUM_ROWS; r++)
                    check_value("sphere pixel", 9'h1ff, pair_pixel(i, c, r));
        @(posedge sysclk);
        #2 mode = MODE_BARS;
        report_test("sphere", e0);
    endtask

    task automatic test_ir_mirror();
        int   e0;
        int   hold;
        logic cur;
        logic hist [$];
        e0   = err_cnt;
        hold = 0;
        cur  = ir_tripped;
        for (int i = 0; i < 300; i++) begin
            @(posedge sysclk);
            #2;
            if (i >= 2)
                check_value("ir mirror", hist[i-2], led[0]);   // two flop delay
            if (hold == 0) begin
                cur  = !cur;
                hold = 1 + rand_bits(3);
            end
            hold--;
            ir_tripped = cur;
            hist.push_back(cur);
        end
        ir_tripped = 1'b0;
        report_test("ir mirror", e0);
    endtask

    task automatic test_rotation();
        int               e0;
        int               period;
        int               slice;
        int               s;
        int               np;
        int               last;
        int               exp_th;
        int               red;
        int               samples;
        int               seen;
        int               distinct;
        int               pulse_t [$];
        logic [PIX_W-1:0] pix;
        e0 = err_cnt;
        apply_reset();   // fresh period measurement
        period = 65536 + rand_bits(12) * 4;
        for (int k = 0; k < 4; k++) begin
            @(posedge sysclk);
            #2 ir_tripped = 1'b1;
            pulse_t.push_back(cycle_cnt);
            repeat (99) @(posedge sysclk);
            #2 ir_tripped = 1'b0;
            repeat (period - 100) @(posedge sysclk);
        end
        slice   = (period - 1) / ROTATIONAL_RES;
        samples = 0;
        seen    = 0;
        for (int i = 0; i < pair_addr.size(); i++) begin
            if (pair_addr[i] != 0)
                continue;
            // theta is taken when the previous pair was accepted
            s  = (i > 0) ? pair_time[i-1] - 2 * NUM_ROWS : 0;
            np = 0;
            last = 0;
            foreach (pulse_t[k])
                if (pulse_t[k] + 3 <= s) begin   // sync delay of the index pulse
                    np++;
                    last = pulse_t[k];
                end
            exp_th = 0;
            if (np >= 2) begin
                exp_th = (s - last - 3) / slice;
                if (exp_th > ROTATIONAL_RES - 1)
                    exp_th = ROTATIONAL_RES - 1;
            end
            pix = pair_pixel(i, 0, 0);
            red = pix[8:6];
            check_value("rotation theta", exp_th & 7, red);
            if (np >= 2) begin
                samples++;
                seen |= 1 << red;
            end
        end
        distinct = $countones(seen);
        check_value("rotation sample count", 1, samples >= 4);
        check_value("rotation theta moves", 1, distinct > 1);
        report_test("rotation", e0);
    endtask

    initial begin
        reset_req  = 1'b0;
        ir_tripped = 1'b0;
        mode       = MODE_BARS;
        lfsr_state = 16'd12;
        @(posedge sysclk);
        wait_reset_release();
        test_reset();
        test_bars();
        test_planes();
        test_sphere();
        test_ir_mirror();
        test_rotation();
        $display("all tests done, %0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire
